//--- list.f
rtl/acq_cfg_pkg.sv
rtl/fill_hdr_pkg.sv
rtl/burst_if.sv
rtl/adc_burst_packer.sv
rtl/fill_header_gen.sv
rtl/fill_store.sv
rtl/adc_fill_top.sv
verif/adc_fill_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = adc_fill_tb
FILELIST  = list.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "TB PASSED"

clean:
	rm -rf obj_dir

//--- verif/adc_fill_tb.sv
`timescale 1ns/1ns

module adc_fill_tb;
	import acq_cfg_pkg::*;
	import fill_hdr_pkg::*;

	localparam int clk_half        = 10;                   // 20 ns period
	localparam int planned_fills   = 5;
	localparam int max_fill_len    = 56;                   // longest fill in bursts
	localparam int watchdog_cycles = planned_fills * max_fill_len * samples_per_burst * 4 + 3000;

	logic         ddr3_domain_clk = 1'b0;
	logic         reset;
	adc_sample_t  adc_sample = '0;
	logic         adc_ovr = 1'b0;
	logic         adc_valid = 1'b0;
	logic         acq_enable;
	logic         acq_trig;
	burst_cnt_t   async_num_bursts;
	fill_num_t    initial_fill_num;
	logic         initial_fill_num_wr;
	channel_tag_t channel_tag;
	logic         acq_done;
	logic         fill_header_fifo_rd_en;
	logic         fill_header_fifo_empty;
	hdr_word_t    fill_header_fifo_out;
	logic         enable_reading;
	burst_addr_t  ddr3_rd_start_addr;
	burst_cnt_t   ddr3_rd_burst_cnt;
	logic         ddr3_rd_fifo_almost_full;
	burst_dat_t   ddr3_rd_fifo_input_dat;
	logic         ddr3_rd_fifo_input_wr;
	logic         ddr3_rd_fifo_input_tlast;
	logic         reading_done;

	integer       seed = 41845;          // $random seed
	logic [31:0]  rnd_word;
	int           sample_cnt = 0;        // index of the next sample to drive
	fill_num_t    model_fill_num;
	channel_tag_t model_tag;
	burst_addr_t  model_wr_addr;         // wraps like the dut write pointer
	int           model_fills;
	burst_dat_t   model_mem [mem_depth];
	hdr_word_t    exp_hdr_q [$];         // headers in fifo order
	burst_dat_t   exp_rd_q [$];          // bursts the readout still owes
	logic         exp_last_q [$];
	int           done_cnt = 0;          // acq_done pulses seen
	logic         af_prev = 1'b0;
	logic         last_prev = 1'b0;      // model says the last burst just went out

	adc_fill_top i_dut (.*);

	always #clk_half ddr3_domain_clk = ~ddr3_domain_clk;

	// counter samples with ovr from bit 3 and a random valid pattern
	always @(posedge ddr3_domain_clk) begin
		#2;
		rnd_word   = $random(seed);
		adc_valid  = rnd_word[0];
		adc_sample = adc_sample_t'(sample_cnt);
		adc_ovr    = sample_cnt[3];
		if (rnd_word[0]) begin
			sample_cnt++;                // counter only moves on valid
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////////////////////

	function automatic burst_dat_t expected_burst(int first_idx);
		burst_dat_t w;
		int         s;
		w = '0;
		for (int i = 0; i < samples_per_burst; i++) begin
			s = first_idx + i;
			w[i*lane_w +: sample_w] = s[sample_w-1:0];   // sample in the low lane bits
			w[i*lane_w + sample_w]  = s[3];              // over-range above it
		end
		return w;
	endfunction

	function automatic hdr_word_t expected_hdr(fill_num_t fill, channel_tag_t tag,
		burst_addr_t start, burst_cnt_t cnt);
		return {fill, tag, start, cnt};                  // top down
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// compare tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic check_hdr(hdr_word_t got, hdr_word_t exp, string what);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s header got %h expected %h", $time, what, got, exp);
			$display("TB FAILED");
			$fatal(1, "header compare failed");
		end
	endtask

	task automatic check_burst(burst_dat_t got, burst_dat_t exp, string what);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s burst got %h expected %h", $time, what, got, exp);
			$display("TB FAILED");
			$fatal(1, "burst compare failed");
		end
	endtask

	task automatic check_flag(logic got, logic exp, string what);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s is %b expected %b", $time, what, got, exp);
			$display("TB FAILED");
			$fatal(1, "flag compare failed");
		end
	endtask

	task automatic check_count(int got, int exp, string what);
		if (got != exp) begin
			$display("Mismatch at %0t: %s count %0d expected %0d", $time, what, got, exp);
			$display("TB FAILED");
			$fatal(1, "count compare failed");
		end
	endtask

	task automatic stop_run(string msg);
		$display("%s", msg);
		$display("TB FAILED");
		$fatal(1, "run stopped");
	endtask

	// readout and acq_done monitor samples the settled outputs at the falling edge
	always @(negedge ddr3_domain_clk) begin
		if (!reset) begin
			check_flag(reading_done, last_prev, "reading_done");   // one clock after the last burst
			last_prev = 1'b0;
			if (ddr3_rd_fifo_input_wr) begin
				if (af_prev) begin
					stop_run("read data was written while almost full was held");
				end else if (exp_rd_q.size() == 0) begin
					stop_run("read data strobe arrived with no burst outstanding");
				end else begin
					check_burst(ddr3_rd_fifo_input_dat, exp_rd_q.pop_front(), "readout");
					last_prev = exp_last_q.pop_front();
					check_flag(ddr3_rd_fifo_input_tlast, last_prev, "tlast");
				end
			end else begin
				check_flag(ddr3_rd_fifo_input_tlast, 1'b0, "tlast without wr");
			end
			if (acq_done) begin
				done_cnt++;
			end
		end
		af_prev = ddr3_rd_fifo_almost_full;
	end

	////////////////////////////////////////////////////////////////////////////
	// stimulus tasks
	////////////////////////////////////////////////////////////////////////////

	// trigger a fill and optionally retrigger retrig_at cycles into the capture
	task automatic run_fill(int n_bursts, int retrig_at);
		int          first_idx;
		burst_addr_t start;
		@(posedge ddr3_domain_clk);
		#2;
		acq_trig         = 1'b1;
		async_num_bursts = burst_cnt_t'(n_bursts);
		@(posedge ddr3_domain_clk);
		first_idx = sample_cnt;                   // next valid sample opens the fill
		#2;
		acq_trig = 1'b0;
		start    = model_wr_addr;
		for (int b = 0; b < n_bursts; b++) begin
			model_mem[model_wr_addr] = expected_burst(first_idx + b * samples_per_burst);
			model_wr_addr++;
		end
		exp_hdr_q.push_back(expected_hdr(model_fill_num, model_tag, start,
			burst_cnt_t'(n_bursts)));
		model_fill_num++;
		model_fills++;
		if (retrig_at > 0) begin
			repeat (retrig_at) @(posedge ddr3_domain_clk);
			#2;
			acq_trig         = 1'b1;              // must be ignored mid capture
			async_num_bursts = burst_cnt_t'(n_bursts + 5);
			@(posedge ddr3_domain_clk);
			#2;
			acq_trig = 1'b0;
		end
		@(negedge ddr3_domain_clk);
		while (acq_done !== 1'b1) begin
			@(negedge ddr3_domain_clk);
		end
		@(negedge ddr3_domain_clk);
		check_flag(acq_done, 1'b0, "acq_done second cycle");
		check_flag(fill_header_fifo_empty, 1'b0, "header fifo empty after fill");
		check_hdr(fill_header_fifo_out, exp_hdr_q[0], "fifo head");
	endtask

	task automatic drain_headers();
		while (exp_hdr_q.size() != 0) begin
			@(negedge ddr3_domain_clk);
			check_flag(fill_header_fifo_empty, 1'b0, "header fifo empty");
			check_hdr(fill_header_fifo_out, exp_hdr_q.pop_front(), "queued");
			@(posedge ddr3_domain_clk);
			#2;
			fill_header_fifo_rd_en = 1'b1;
			@(posedge ddr3_domain_clk);
			#2;
			fill_header_fifo_rd_en = 1'b0;
		end
		@(negedge ddr3_domain_clk);
		check_flag(fill_header_fifo_empty, 1'b1, "header fifo empty after drain");
	endtask

	// read cnt bursts from start and hold almost full for hold_len cycles
	task automatic read_range(burst_addr_t start, int cnt, int hold_at, int hold_len);
		burst_addr_t a;
		a = start;
		for (int i = 0; i < cnt; i++) begin
			exp_rd_q.push_back(model_mem[a]);
			exp_last_q.push_back(i == cnt - 1);
			a++;                                  // wraps past 63
		end
		@(posedge ddr3_domain_clk);
		#2;
		enable_reading     = 1'b1;
		ddr3_rd_start_addr = start;
		ddr3_rd_burst_cnt  = burst_cnt_t'(cnt);
		@(posedge ddr3_domain_clk);
		#2;
		enable_reading = 1'b0;
		if (hold_len > 0) begin
			repeat (hold_at) @(posedge ddr3_domain_clk);
			#2;
			ddr3_rd_fifo_almost_full = 1'b1;
			repeat (hold_len) @(posedge ddr3_domain_clk);
			#2;
			ddr3_rd_fifo_almost_full = 1'b0;
		end
		@(negedge ddr3_domain_clk);
		while (reading_done !== 1'b1) begin
			@(negedge ddr3_domain_clk);
		end
		if (exp_rd_q.size() != 0) begin
			stop_run("reading_done came before all bursts were read");
		end
	endtask

	task automatic quiet_check(string what);
		repeat (40) @(posedge ddr3_domain_clk);  // longer than a stray 1-burst fill
		#2;
		check_count(done_cnt, model_fills, what);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		reset                    = 1'b1;
		acq_enable               = 1'b0;
		acq_trig                 = 1'b0;
		async_num_bursts         = '0;
		initial_fill_num         = '0;
		initial_fill_num_wr      = 1'b0;
		channel_tag              = '0;
		fill_header_fifo_rd_en   = 1'b0;
		enable_reading           = 1'b0;
		ddr3_rd_start_addr       = '0;
		ddr3_rd_burst_cnt        = '0;
		ddr3_rd_fifo_almost_full = 1'b0;
		model_wr_addr            = '0;
		model_fills              = 0;
		repeat (3) @(posedge ddr3_domain_clk);
		#2;
		reset = 1'b0;
		@(negedge ddr3_domain_clk);
		check_flag(acq_done, 1'b0, "acq_done after reset");
		check_flag(fill_header_fifo_empty, 1'b1, "header fifo empty after reset");
		check_flag(ddr3_rd_fifo_input_wr, 1'b0, "read wr after reset");
		check_flag(reading_done, 1'b0, "reading_done after reset");

		// fills of 3 and 5 from fill number 0x55, tag 8
		@(posedge ddr3_domain_clk);
		#2;
		initial_fill_num    = 24'h55;
		initial_fill_num_wr = 1'b1;
		channel_tag         = 16'd8;
		acq_enable          = 1'b1;
		model_fill_num      = 24'h55;
		model_tag           = 16'd8;
		@(posedge ddr3_domain_clk);
		#2;
		initial_fill_num_wr = 1'b0;
		run_fill(3, 0);
		run_fill(5, 0);
		drain_headers();
		read_range(burst_addr_t'(0), 8, 0, 0);

		// triggers that must not start a fill
		@(posedge ddr3_domain_clk);
		#2;
		acq_enable       = 1'b0;
		acq_trig         = 1'b1;
		async_num_bursts = burst_cnt_t'(1);
		@(posedge ddr3_domain_clk);
		#2;
		acq_trig = 1'b0;
		quiet_check("fills with acq_enable low");
		check_flag(fill_header_fifo_empty, 1'b1, "header fifo after disabled trigger");
		acq_enable = 1'b1;
		run_fill(4, 10);
		quiet_check("fills after a retrigger");
		drain_headers();

		// back-pressure in the middle of a readout
		read_range(burst_addr_t'(8), 4, 2, 6);

		// write pointer and readout across the wrap
		run_fill(56, 0);
		run_fill(3, 0);
		drain_headers();
		read_range(burst_addr_t'(62), 8, 0, 0);

		$display("TB PASSED");
		$finish;
	end

	initial begin
		#(watchdog_cycles * 2 * clk_half);
		$display("the run timed out after %0d cycles", watchdog_cycles);
		$display("TB FAILED");
		$fatal(1, "watchdog expired");
	end

endmodule

//--- rtl/adc_fill_top.sv
`timescale 1ns/1ns

module adc_fill_top (
	input  logic                       ddr3_domain_clk,
	input  logic                       reset,
	// adc sample stream
	input  acq_cfg_pkg::adc_sample_t   adc_sample,
	input  logic                       adc_ovr,
	input  logic                       adc_valid,
	// acquisition control
	input  logic                       acq_enable,
	input  logic                       acq_trig,
	input  acq_cfg_pkg::burst_cnt_t    async_num_bursts,
	input  fill_hdr_pkg::fill_num_t    initial_fill_num,
	input  logic                       initial_fill_num_wr,
	input  fill_hdr_pkg::channel_tag_t channel_tag,
	output logic                       acq_done,                // fill complete, header queued
	// header fifo
	input  logic                       fill_header_fifo_rd_en,
	output logic                       fill_header_fifo_empty,
	output fill_hdr_pkg::hdr_word_t    fill_header_fifo_out,
	// readout
	input  logic                       enable_reading,
	input  acq_cfg_pkg::burst_addr_t   ddr3_rd_start_addr,
	input  acq_cfg_pkg::burst_cnt_t    ddr3_rd_burst_cnt,
	input  logic                       ddr3_rd_fifo_almost_full,
	output acq_cfg_pkg::burst_dat_t    ddr3_rd_fifo_input_dat,
	output logic                       ddr3_rd_fifo_input_wr,
	output logic                       ddr3_rd_fifo_input_tlast,
	output logic                       reading_done
);
	import acq_cfg_pkg::*;
	import fill_hdr_pkg::*;

	burst_addr_t wr_addr;       // header gen owns the write pointer
	hdr_word_t   hdr_dat;       // header on its way to the fifo

	burst_if burst_bus ();      // packer -> header gen + store

	adc_burst_packer i_packer (
		.ddr3_domain_clk  (ddr3_domain_clk),
		.reset            (reset),
		.adc_sample       (adc_sample),
		.adc_ovr          (adc_ovr),
		.adc_valid        (adc_valid),
		.acq_enable       (acq_enable),
		.acq_trig         (acq_trig),
		.async_num_bursts (async_num_bursts),
		.burst            (burst_bus.src)
	);

	fill_header_gen i_hdr_gen (
		.ddr3_domain_clk     (ddr3_domain_clk),
		.reset               (reset),
		.burst               (burst_bus.hdr_sink),
		.initial_fill_num    (initial_fill_num),
		.initial_fill_num_wr (initial_fill_num_wr),
		.channel_tag         (channel_tag),
		.wr_addr             (wr_addr),
		.hdr_wr              (acq_done),            // header strobe doubles as acq_done
		.hdr_dat             (hdr_dat)
	);

	fill_store i_store (
		.ddr3_domain_clk          (ddr3_domain_clk),
		.reset                    (reset),
		.burst                    (burst_bus.store_sink),
		.wr_addr                  (wr_addr),
		.hdr_wr                   (acq_done),
		.hdr_dat                  (hdr_dat),
		.fill_header_fifo_rd_en   (fill_header_fifo_rd_en),
		.fill_header_fifo_empty   (fill_header_fifo_empty),
		.fill_header_fifo_out     (fill_header_fifo_out),
		.enable_reading           (enable_reading),
		.ddr3_rd_start_addr       (ddr3_rd_start_addr),
		.ddr3_rd_burst_cnt        (ddr3_rd_burst_cnt),
		.ddr3_rd_fifo_almost_full (ddr3_rd_fifo_almost_full),
		.ddr3_rd_fifo_input_dat   (ddr3_rd_fifo_input_dat),
		.ddr3_rd_fifo_input_wr    (ddr3_rd_fifo_input_wr),
		.ddr3_rd_fifo_input_tlast (ddr3_rd_fifo_input_tlast),
		.reading_done             (reading_done)
	);

endmodule

//--- rtl/fill_store.sv
`timescale 1ns/1ns

module fill_store (
	input  logic                     ddr3_domain_clk,
	input  logic                     reset,
	burst_if.store_sink              burst,
	input  acq_cfg_pkg::burst_addr_t wr_addr,
	input  logic                     hdr_wr,
	input  fill_hdr_pkg::hdr_word_t  hdr_dat,
	input  logic                     fill_header_fifo_rd_en,     // pop the head
	output logic                     fill_header_fifo_empty,
	output fill_hdr_pkg::hdr_word_t  fill_header_fifo_out,       // head, shown ahead of pop
	input  logic                     enable_reading,             // start strobe
	input  acq_cfg_pkg::burst_addr_t ddr3_rd_start_addr,
	input  acq_cfg_pkg::burst_cnt_t  ddr3_rd_burst_cnt,
	input  logic                     ddr3_rd_fifo_almost_full,   // downstream back-pressure
	output acq_cfg_pkg::burst_dat_t  ddr3_rd_fifo_input_dat,
	output logic                     ddr3_rd_fifo_input_wr,
	output logic                     ddr3_rd_fifo_input_tlast,
	output logic                     reading_done
);
	import acq_cfg_pkg::*;
	import fill_hdr_pkg::*;

	typedef enum logic [0:0] {
		rd_idle,
		rd_read
	} rd_state_t;

	////////////////////////////////////////////////////////////////////////////
	// burst array, stands in for the ddr3
	////////////////////////////////////////////////////////////////////////////

	burst_dat_t burst_mem [mem_depth];

	always_ff @(posedge ddr3_domain_clk) begin
		if (burst.burst_wr) begin
			burst_mem[wr_addr] <= burst.burst_dat;      // accepted in the strobe cycle
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// header fifo
	////////////////////////////////////////////////////////////////////////////

	hdr_word_t hdr_mem [hdr_fifo_depth];
	hdr_ptr_t  hdr_wr_ptr;
	hdr_ptr_t  hdr_rd_ptr;
	hdr_cnt_t  hdr_count;
	logic      hdr_full;
	logic      hdr_push;
	logic      hdr_pop;

	assign hdr_full               = (hdr_count == hdr_cnt_t'(hdr_fifo_depth));
	assign fill_header_fifo_empty = (hdr_count == '0);
	assign hdr_push               = hdr_wr && !hdr_full;       // drop when full
	assign hdr_pop                = fill_header_fifo_rd_en && !fill_header_fifo_empty;
	assign fill_header_fifo_out   = hdr_mem[hdr_rd_ptr];

	always_ff @(posedge ddr3_domain_clk) begin
		if (reset) begin
			hdr_wr_ptr <= '0;
			hdr_rd_ptr <= '0;
			hdr_count  <= '0;
		end else begin
			if (hdr_push) begin
				hdr_wr_ptr <= hdr_wr_ptr + 1'b1;
			end
			if (hdr_pop) begin
				hdr_rd_ptr <= hdr_rd_ptr + 1'b1;
			end
			case ({hdr_push, hdr_pop})
				2'b10:   hdr_count <= hdr_count + 1'b1;
				2'b01:   hdr_count <= hdr_count - 1'b1;
				default: hdr_count <= hdr_count;        // both or neither
			endcase
		end
	end

	always_ff @(posedge ddr3_domain_clk) begin
		if (hdr_push) begin
			hdr_mem[hdr_wr_ptr] <= hdr_dat;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// readout engine
	////////////////////////////////////////////////////////////////////////////

	rd_state_t   rd_state;
	burst_addr_t rd_addr;       // next burst to fetch, wraps
	burst_cnt_t  rd_left;       // bursts still to fetch
	logic        rd_issue;      // memory read this cycle

	assign rd_issue = (rd_state == rd_read) && !ddr3_rd_fifo_almost_full;

	always_ff @(posedge ddr3_domain_clk) begin
		if (reset) begin
			rd_state                 <= rd_idle;
			rd_addr                  <= '0;
			rd_left                  <= '0;
			ddr3_rd_fifo_input_wr    <= 1'b0;
			ddr3_rd_fifo_input_tlast <= 1'b0;
			reading_done             <= 1'b0;
		end else begin
			ddr3_rd_fifo_input_wr    <= rd_issue;
			ddr3_rd_fifo_input_tlast <= rd_issue && (rd_left == burst_cnt_t'(1));
			reading_done             <= ddr3_rd_fifo_input_wr && ddr3_rd_fifo_input_tlast;
			case (rd_state)
				rd_idle: begin
					if (enable_reading && (ddr3_rd_burst_cnt != '0)) begin
						rd_addr  <= ddr3_rd_start_addr;
						rd_left  <= ddr3_rd_burst_cnt;
						rd_state <= rd_read;
					end
				end
				rd_read: begin
					if (rd_issue) begin
						rd_addr <= rd_addr + 1'b1;
						rd_left <= rd_left - 1'b1;
						if (rd_left == burst_cnt_t'(1)) begin
							rd_state <= rd_idle;            // last burst issued
						end
					end
				end
				default: rd_state <= rd_idle;
			endcase
		end
	end

	// read data lands one clock after the issue
	always_ff @(posedge ddr3_domain_clk) begin
		if (rd_issue) begin
			ddr3_rd_fifo_input_dat <= burst_mem[rd_addr];
		end
	end

	a_hdr_push_full: assert property (@(posedge ddr3_domain_clk) disable iff (reset)
		hdr_wr |-> !hdr_full)
		else $error("header fifo full, fill header dropped");

	a_hdr_pop_empty: assert property (@(posedge ddr3_domain_clk) disable iff (reset)
		fill_header_fifo_rd_en |-> !fill_header_fifo_empty)
		else $error("header fifo popped while empty");

endmodule

//--- rtl/fill_header_gen.sv
`timescale 1ns/1ns

module fill_header_gen (
	input  logic                       ddr3_domain_clk,
	input  logic                       reset,
	burst_if.hdr_sink                  burst,
	input  fill_hdr_pkg::fill_num_t    initial_fill_num,     // first fill number
	input  logic                       initial_fill_num_wr,  // load strobe
	input  fill_hdr_pkg::channel_tag_t channel_tag,
	output acq_cfg_pkg::burst_addr_t   wr_addr,              // where the next burst lands
	output logic                       hdr_wr,               // header ready, one cycle
	output fill_hdr_pkg::hdr_word_t    hdr_dat
);
	import acq_cfg_pkg::*;
	import fill_hdr_pkg::*;

	fill_num_t    fill_num;       // number of the fill in progress
	channel_tag_t tag_q;          // tag latched at the first burst
	burst_addr_t  start_addr;     // address of the first burst
	burst_cnt_t   fill_bursts;    // bursts written so far in this fill
	channel_tag_t tag_nxt;
	burst_addr_t  start_nxt;
	burst_cnt_t   count_nxt;
	hdr_word_t    hdr_nxt;
	logic         fill_end;       // last burst is being written

	// a one-burst fill is first and last at once, so bypass the latches
	assign start_nxt = burst.burst_first ? wr_addr : start_addr;
	assign tag_nxt   = burst.burst_first ? channel_tag : tag_q;
	assign count_nxt = burst.burst_first ? burst_cnt_t'(1) : fill_bursts + 1'b1;
	assign fill_end  = burst.burst_wr && burst.burst_last;

	always_comb begin
		hdr_nxt = '0;
		hdr_nxt[hdr_fill_lsb +: fill_num_w]    = fill_num;
		hdr_nxt[hdr_tag_lsb +: channel_tag_w]  = tag_nxt;
		hdr_nxt[hdr_addr_lsb +: mem_addr_w]    = start_nxt;
		hdr_nxt[hdr_cnt_lsb +: burst_cnt_w]    = count_nxt;
	end

	////////////////////////////////////////////////////////////////////////////
	// address, fill number and burst count
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge ddr3_domain_clk) begin
		if (reset) begin
			wr_addr     <= '0;
			fill_num    <= '0;
			fill_bursts <= '0;
			hdr_wr      <= 1'b0;
		end else begin
			hdr_wr <= fill_end;
			if (burst.burst_wr) begin
				wr_addr     <= wr_addr + 1'b1;              // wraps mod 64
				fill_bursts <= count_nxt;
			end
			if (initial_fill_num_wr) begin
				fill_num <= initial_fill_num;
			end else if (fill_end) begin
				fill_num <= fill_num + 1'b1;                // next fill gets the next number
			end
		end
	end

	// header payload and first-burst latches
	always_ff @(posedge ddr3_domain_clk) begin
		if (burst.burst_wr && burst.burst_first) begin
			start_addr <= wr_addr;
			tag_q      <= channel_tag;
		end
		if (fill_end) begin
			hdr_dat <= hdr_nxt;
		end
	end

endmodule

//--- rtl/adc_burst_packer.sv
`timescale 1ns/1ns

module adc_burst_packer (
	input  logic                     ddr3_domain_clk,
	input  logic                     reset,
	input  acq_cfg_pkg::adc_sample_t adc_sample,        // 12-bit sample
	input  logic                     adc_ovr,           // over-range for this sample
	input  logic                     adc_valid,         // sample strobe
	input  logic                     acq_enable,        // triggers accepted while high
	input  logic                     acq_trig,          // start a fill
	input  acq_cfg_pkg::burst_cnt_t  async_num_bursts,  // bursts per fill as latched on trigger
	burst_if.src                     burst
);
	import acq_cfg_pkg::*;

	typedef enum logic [0:0] {
		pk_idle,
		pk_capture
	} pk_state_t;

	pk_state_t           state;
	lane_idx_t           lane_cnt;      // next lane to fill
	burst_cnt_t          burst_cnt;     // bursts finished in this fill
	burst_cnt_t          num_bursts;    // fill length from the trigger
	burst_dat_t          pack_reg;      // burst under assembly
	logic [lane_w-1:0]   lane_word;     // sample as it sits in its lane
	logic                sample_take;   // valid sample counted in this fill
	logic                burst_done;    // 8th sample of a burst
	logic                fill_done;     // 8th sample of the final burst

	assign sample_take = (state == pk_capture) && adc_valid;
	assign burst_done  = sample_take && (lane_cnt == lane_idx_t'(samples_per_burst - 1));
	assign fill_done   = burst_done && (burst_cnt == num_bursts - 1'b1);
	assign lane_word   = {{(lane_w - sample_w - 1){1'b0}}, adc_ovr, adc_sample};

	////////////////////////////////////////////////////////////////////////////
	// fill control
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge ddr3_domain_clk) begin
		if (reset) begin
			state      <= pk_idle;
			lane_cnt   <= '0;
			burst_cnt  <= '0;
			num_bursts <= burst_cnt_t'(1);
		end else begin
			case (state)
				pk_idle: begin
					if (acq_enable && acq_trig) begin          // trigger only counts here
						state     <= pk_capture;
						lane_cnt  <= '0;
						burst_cnt <= '0;
						num_bursts <= (async_num_bursts == '0) ? burst_cnt_t'(1)
							: async_num_bursts;                 // zero length means one burst
					end
				end
				pk_capture: begin
					if (sample_take) begin
						lane_cnt <= lane_cnt + 1'b1;            // wraps after lane 7
					end
					if (burst_done) begin
						burst_cnt <= burst_cnt + 1'b1;
					end
					if (fill_done) begin
						state <= pk_idle;                       // rearm for the next trigger
					end
				end
				default: state <= pk_idle;
			endcase
		end
	end

	// lanes fill in place and the full burst sits on pack_reg the cycle after lane 7
	always_ff @(posedge ddr3_domain_clk) begin
		if (sample_take) begin
			pack_reg[lane_cnt * lane_w +: lane_w] <= lane_word;
		end
	end

	assign burst.burst_dat = pack_reg;

	// strobes trail the 8th sample by one clock to line up with pack_reg
	always_ff @(posedge ddr3_domain_clk) begin
		if (reset) begin
			burst.burst_wr    <= 1'b0;
			burst.burst_first <= 1'b0;
			burst.burst_last  <= 1'b0;
		end else begin
			burst.burst_wr    <= burst_done;
			burst.burst_first <= burst_done && (burst_cnt == '0);
			burst.burst_last  <= fill_done;
		end
	end

	// fill marks ride on the write strobe and agree with the bursts counted so far
	a_fill_marks: assert property (@(posedge ddr3_domain_clk) disable iff (reset)
		(burst.burst_first || burst.burst_last || burst.burst_wr) |-> burst.burst_wr
			&& (burst.burst_first == (burst_cnt == burst_cnt_t'(1)))
			&& (burst.burst_last == (burst_cnt == num_bursts)))
		else $error("burst fill mark out of step with burst_wr or the fill count");

endmodule

//--- rtl/burst_if.sv
`timescale 1ns/1ns

interface burst_if;
	import acq_cfg_pkg::*;

	logic       burst_wr;       // one complete burst this cycle
	burst_dat_t burst_dat;      // 8 lanes of sample + over-range
	logic       burst_first;    // first burst of a fill
	logic       burst_last;     // last burst of a fill

	// packer side
	modport src (
		output burst_wr, burst_dat, burst_first, burst_last
	);

	// header generator only needs the strobes and fill marks
	modport hdr_sink (
		input burst_wr, burst_first, burst_last
	);

	// memory side takes the data
	modport store_sink (
		input burst_wr, burst_dat
	);

endinterface

//--- rtl/fill_hdr_pkg.sv
package fill_hdr_pkg;

	localparam int fill_num_w    = 24;          // fill counter width
	localparam int channel_tag_w = 16;          // channel tag width

	////////////////////////////////////////////////////////////////////////////
	// header word, top down: fill number, channel tag, start address, count
	////////////////////////////////////////////////////////////////////////////

	localparam int hdr_cnt_lsb  = 0;                                        // burst count
	localparam int hdr_addr_lsb = hdr_cnt_lsb + acq_cfg_pkg::burst_cnt_w;   // start address
	localparam int hdr_tag_lsb  = hdr_addr_lsb + acq_cfg_pkg::mem_addr_w;   // channel tag
	localparam int hdr_fill_lsb = hdr_tag_lsb + channel_tag_w;              // fill number
	localparam int hdr_w        = hdr_fill_lsb + fill_num_w;                // 57 bits total

	typedef logic [fill_num_w-1:0]    fill_num_t;
	typedef logic [channel_tag_w-1:0] channel_tag_t;
	typedef logic [hdr_w-1:0]         hdr_word_t;

	// header queue
	localparam int hdr_fifo_depth = 4;
	localparam int hdr_ptr_w      = $clog2(hdr_fifo_depth);

	typedef logic [hdr_ptr_w-1:0] hdr_ptr_t;    // fifo read/write pointer
	typedef logic [hdr_ptr_w:0]   hdr_cnt_t;    // fifo occupancy, 0..depth

endpackage

//--- rtl/acq_cfg_pkg.sv
package acq_cfg_pkg;

	////////////////////////////////////////////////////////////////////////////
	// sample and burst geometry
	////////////////////////////////////////////////////////////////////////////

	localparam int sample_w          = 12;                        // adc sample bits
	localparam int samples_per_burst = 8;                         // samples packed per burst
	localparam int lane_w            = 16;                        // one 16-bit lane per sample
	localparam int burst_w           = 128;                       // samples_per_burst * lane_w
	localparam int lane_idx_w        = $clog2(samples_per_burst); // lane select bits

	// lane i of a burst holds the sample in bits [11:0], the over-range
	// flag in bit 12 and zeros above that

	////////////////////////////////////////////////////////////////////////////
	// burst memory
	////////////////////////////////////////////////////////////////////////////

	localparam int mem_addr_w  = 6;                 // 64 bursts on chip, addresses wrap
	localparam int mem_depth   = 2 ** mem_addr_w;   // entries in the burst array
	localparam int burst_cnt_w = 11;                // bursts per fill

	typedef logic [sample_w-1:0]    adc_sample_t;   // raw adc sample
	typedef logic [burst_w-1:0]     burst_dat_t;    // one packed 8-sample burst
	typedef logic [mem_addr_w-1:0]  burst_addr_t;   // burst memory address
	typedef logic [burst_cnt_w-1:0] burst_cnt_t;    // number of bursts
	typedef logic [lane_idx_w-1:0]  lane_idx_t;     // lane within a burst

endpackage
